/* hw/simt_pkg.sv */
`default_nettype none

package simt_pkg;

    typedef logic [31:0] data_t;
    typedef logic [7:0]  imem_addr_t;
    typedef logic [7:0]  dmem_addr_t;
    typedef logic [4:0]  reg_addr_t;

    // Per-warp progress through one instruction
    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_REQUEST,
        WARP_WAIT,
        WARP_EXECUTE,
        WARP_UPDATE,
        WARP_DONE
    } warp_state_t;

    // Carried in funct3 of R-type and I-type words
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_HALT  = 7'b1111111;

    // Read-only register that returns the global thread id
    localparam reg_addr_t TID_REG = 5'd31;

    // Opcode sits in the same bits in every view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r_fields;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i_fields;
        struct packed {
            logic [6:0] imm_hi;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fields;
    } instruction_t;

endpackage

`default_nettype wire

/* hw/instr_fetcher.sv */
`default_nettype none

module instr_fetcher (
    input  wire                     clk,
    input  wire                     reset,
    input  simt_pkg::warp_state_t   warp_state,
    input  simt_pkg::imem_addr_t    pc,
    input  logic                    imem_ready,
    input  simt_pkg::instruction_t  imem_data,
    output logic                    imem_valid,
    output simt_pkg::imem_addr_t    imem_addr,
    output logic                    fetch_done,
    output simt_pkg::instruction_t  instruction
);
    import simt_pkg::*;

    localparam logic [1:0] F_IDLE     = 2'd0;
    localparam logic [1:0] F_FETCHING = 2'd1;
    localparam logic [1:0] F_DONE     = 2'd2;

    logic [1:0] fstate;

    // Request goes out in the first fetch cycle and holds until accepted
    assign imem_valid = (fstate == F_IDLE && warp_state == WARP_FETCH) || fstate == F_FETCHING;
    // PC only moves in update, so it is stable for the whole fetch
    assign imem_addr  = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            fstate     <= F_IDLE;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (fstate)
                F_IDLE, F_FETCHING: begin
                    if (imem_valid && imem_ready) begin
                        fstate     <= F_DONE;
                        fetch_done <= 1'b1;
                    end else if (imem_valid) begin
                        fstate <= F_FETCHING;
                    end
                end
                F_DONE: begin
                    // Rearm once the warp has left fetch
                    if (warp_state != WARP_FETCH) fstate <= F_IDLE;
                end
                default: fstate <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (imem_valid && imem_ready) instruction <= imem_data;
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr));

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`default_nettype none

module instr_decoder (
    input  wire                     clk,
    input  wire                     reset,
    input  logic                    decode_en,
    input  simt_pkg::instruction_t  instruction,
    output simt_pkg::alu_op_t       alu_op,
    output logic                    use_imm,
    output simt_pkg::data_t         imm,
    output simt_pkg::reg_addr_t     rd,
    output simt_pkg::reg_addr_t     rs1,
    output simt_pkg::reg_addr_t     rs2,
    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    halt
);
    import simt_pkg::*;

    logic [6:0] opcode;

    assign opcode = instruction.r_fields.opcode;

    // Control flags; anything unrecognised leaves all three low
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write <= 1'b0;
            mem_write <= 1'b0;
            halt      <= 1'b0;
        end else if (decode_en) begin
            reg_write <= 1'b0;
            mem_write <= 1'b0;
            halt      <= 1'b0;
            case (opcode)
                OP_REG:   reg_write <= (instruction.r_fields.funct3 <= ALU_SLT);
                OP_IMM:   reg_write <= (instruction.i_fields.funct3 <= ALU_SLT);
                OP_STORE: mem_write <= 1'b1;
                OP_HALT:  halt      <= 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            alu_op  <= alu_op_t'(instruction.r_fields.funct3);
            rd      <= instruction.r_fields.rd;
            rs1     <= instruction.r_fields.rs1;
            rs2     <= instruction.r_fields.rs2;
            use_imm <= (opcode == OP_IMM);
            if (opcode == OP_STORE) begin
                imm <= {{20{instruction.s_fields.imm_hi[6]}},
                        instruction.s_fields.imm_hi, instruction.s_fields.imm_lo};
            end else begin
                imm <= {{20{instruction.i_fields.imm12[11]}}, instruction.i_fields.imm12};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/vector_reg_file.sv */
`default_nettype none

module vector_reg_file #(
    parameter int WARPS_PER_CORE   = 2,
    parameter int THREADS_PER_WARP = 4,
    localparam int WARP_W = (WARPS_PER_CORE > 1) ? $clog2(WARPS_PER_CORE) : 1
) (
    input  wire                  clk,
    input  wire                  reset,
    input  logic [WARP_W-1:0]    current_warp,
    input  simt_pkg::reg_addr_t  rs1,
    input  simt_pkg::reg_addr_t  rs2,
    input  simt_pkg::reg_addr_t  rd,
    input  logic                 write_en,
    input  simt_pkg::data_t      wdata [THREADS_PER_WARP],
    output simt_pkg::data_t      rs1_data [THREADS_PER_WARP],
    output simt_pkg::data_t      rs2_data [THREADS_PER_WARP]
);
    import simt_pkg::*;

    // Only x1..x30 have storage
    data_t regs [WARPS_PER_CORE][THREADS_PER_WARP][1:30];

    function automatic data_t read_reg(input reg_addr_t addr, input int lane);
        if (addr == '0) return '0;
        if (addr == TID_REG) return data_t'(int'(current_warp) * THREADS_PER_WARP + lane);
        return regs[current_warp][lane][addr];
    endfunction

    always_comb begin
        for (int l = 0; l < THREADS_PER_WARP; l++) begin
            rs1_data[l] = read_reg(rs1, l);
            rs2_data[l] = read_reg(rs2, l);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WARPS_PER_CORE; w++) begin
                for (int l = 0; l < THREADS_PER_WARP; l++) begin
                    for (int r = 1; r <= 30; r++) begin
                        regs[w][l][r] <= '0;
                    end
                end
            end
        end else if (write_en && rd != '0 && rd != TID_REG) begin
            for (int l = 0; l < THREADS_PER_WARP; l++) begin
                regs[current_warp][l][rd] <= wdata[l];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/lane_alu.sv */
`default_nettype none

module lane_alu (
    input  wire                clk,
    input  wire                reset,
    input  logic               execute_en,
    input  simt_pkg::alu_op_t  alu_op,
    input  logic               use_imm,
    input  simt_pkg::data_t    rs1_data,
    input  simt_pkg::data_t    rs2_data,
    input  simt_pkg::data_t    imm,
    output simt_pkg::data_t    result
);
    import simt_pkg::*;

    data_t b;

    assign b = use_imm ? imm : rs2_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (execute_en) begin
            case (alu_op)
                ALU_ADD: result <= rs1_data + b;
                ALU_SUB: result <= rs1_data - b;
                ALU_AND: result <= rs1_data & b;
                ALU_OR:  result <= rs1_data | b;
                ALU_XOR: result <= rs1_data ^ b;
                ALU_SLT: result <= data_t'($signed(rs1_data) < $signed(b));
                default: result <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/lane_store_unit.sv */
`default_nettype none

module lane_store_unit (
    input  wire                   clk,
    input  wire                   reset,
    input  logic                  store_req,
    input  logic                  mem_write,
    input  simt_pkg::data_t       rs1_data,
    input  simt_pkg::data_t       rs2_data,
    input  simt_pkg::data_t       imm,
    input  logic                  dmem_wready,
    output logic                  dmem_wvalid,
    output simt_pkg::dmem_addr_t  dmem_waddr,
    output simt_pkg::data_t       dmem_wdata,
    output logic                  busy
);
    import simt_pkg::*;

    logic issue;

    assign issue = store_req && mem_write && !dmem_wvalid;
    // Counts from the request pulse until the handshake
    assign busy  = issue || dmem_wvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            dmem_wvalid <= 1'b0;
        end else if (dmem_wvalid && dmem_wready) begin
            dmem_wvalid <= 1'b0;
        end else if (issue) begin
            dmem_wvalid <= 1'b1;
        end
    end

    // Address wraps to the 8-bit data space
    always_ff @(posedge clk) begin
        if (issue) begin
            dmem_waddr <= dmem_addr_t'(rs1_data + imm);
            dmem_wdata <= rs2_data;
        end
    end

    a_hold_until_ready: assert property (@(posedge clk) disable iff (reset)
        dmem_wvalid && !dmem_wready |=>
            dmem_wvalid && $stable(dmem_waddr) && $stable(dmem_wdata));

endmodule

`default_nettype wire

/* hw/warp_scheduler.sv */
`default_nettype none

module warp_scheduler #(
    parameter int WARPS_PER_CORE   = 2,
    parameter int THREADS_PER_WARP = 4,
    localparam int COUNT_W = $clog2(WARPS_PER_CORE + 1),
    localparam int WARP_W  = (WARPS_PER_CORE > 1) ? $clog2(WARPS_PER_CORE) : 1
) (
    input  wire                          clk,
    input  wire                          reset,
    input  logic                         start,
    input  logic [COUNT_W-1:0]           num_warps,
    input  simt_pkg::imem_addr_t         base_addr,
    input  logic [WARPS_PER_CORE-1:0]    fetch_done,
    input  logic                         halt,
    input  logic [THREADS_PER_WARP-1:0]  lane_busy,
    output simt_pkg::warp_state_t        warp_state [WARPS_PER_CORE],
    output simt_pkg::imem_addr_t         pc [WARPS_PER_CORE],
    output logic [WARP_W-1:0]            current_warp,
    output logic                         store_req,
    output logic                         done
);
    import simt_pkg::*;

    logic              running;
    logic              all_done;
    logic [WARP_W-1:0] next_warp;

    // Lanes see the request stage as a single-cycle pulse
    assign store_req = (warp_state[current_warp] == WARP_REQUEST);

    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < WARPS_PER_CORE; i++) begin
            if (i < num_warps && warp_state[i] != WARP_DONE) begin
                all_done = 1'b0;
            end
        end
    end

    // The nearest fetched warp after the current one wins in round-robin order
    always_comb begin
        int idx;
        next_warp = current_warp;
        for (int i = WARPS_PER_CORE; i >= 1; i--) begin
            idx = (int'(current_warp) + i) % WARPS_PER_CORE;
            if (warp_state[idx] inside {WARP_DECODE, WARP_REQUEST, WARP_WAIT,
                                        WARP_EXECUTE, WARP_UPDATE}) begin
                next_warp = WARP_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running      <= 1'b0;
            done         <= 1'b0;
            current_warp <= '0;
            for (int i = 0; i < WARPS_PER_CORE; i++) begin
                warp_state[i] <= WARP_IDLE;
                pc[i]         <= '0;
            end
        end else if (!running) begin
            if (start) begin
                running      <= 1'b1;
                current_warp <= '0;
                for (int i = 0; i < WARPS_PER_CORE; i++) begin
                    if (i < num_warps) begin
                        warp_state[i] <= WARP_FETCH;
                        pc[i]         <= base_addr;
                    end
                end
            end
        end else begin
            done <= all_done;

            // Fetches complete in parallel with the current warp
            for (int i = 0; i < WARPS_PER_CORE; i++) begin
                if (warp_state[i] == WARP_FETCH && fetch_done[i]) begin
                    warp_state[i] <= WARP_DECODE;
                end
            end

            if (warp_state[current_warp] inside {WARP_UPDATE, WARP_DONE}) begin
                current_warp <= next_warp;
            end

            case (warp_state[current_warp])
                WARP_DECODE:  warp_state[current_warp] <= WARP_REQUEST;
                WARP_REQUEST: warp_state[current_warp] <= WARP_WAIT;
                WARP_WAIT: begin
                    if (lane_busy == '0) begin
                        warp_state[current_warp] <= WARP_EXECUTE;
                    end
                end
                WARP_EXECUTE: warp_state[current_warp] <= WARP_UPDATE;
                WARP_UPDATE: begin
                    if (halt) begin
                        warp_state[current_warp] <= WARP_DONE;
                    end else begin
                        warp_state[current_warp] <= WARP_FETCH;
                        pc[current_warp]         <= pc[current_warp] + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    a_warp_in_range: assert property (@(posedge clk) disable iff (reset)
        running |-> current_warp < num_warps);

    a_done_sticky: assert property (@(posedge clk) disable iff (reset)
        done |=> done);

endmodule

`default_nettype wire

/* hw/compute_core.sv */
`default_nettype none

module compute_core #(
    parameter int WARPS_PER_CORE   = 2,
    parameter int THREADS_PER_WARP = 4,
    localparam int COUNT_W = $clog2(WARPS_PER_CORE + 1)
) (
    input  wire                           clk,
    input  wire                           reset,
    input  logic                          start,
    input  logic [COUNT_W-1:0]            num_warps,
    input  simt_pkg::imem_addr_t          base_addr,
    output logic                          done,

    output logic [WARPS_PER_CORE-1:0]     imem_valid,
    output simt_pkg::imem_addr_t          imem_addr [WARPS_PER_CORE],
    input  logic [WARPS_PER_CORE-1:0]     imem_ready,
    input  simt_pkg::instruction_t        imem_data [WARPS_PER_CORE],

    output logic [THREADS_PER_WARP-1:0]   dmem_wvalid,
    output simt_pkg::dmem_addr_t          dmem_waddr [THREADS_PER_WARP],
    output simt_pkg::data_t               dmem_wdata [THREADS_PER_WARP],
    input  logic [THREADS_PER_WARP-1:0]   dmem_wready
);
    import simt_pkg::*;

    localparam int WARP_W = (WARPS_PER_CORE > 1) ? $clog2(WARPS_PER_CORE) : 1;

    warp_state_t               warp_state [WARPS_PER_CORE];
    imem_addr_t                pc [WARPS_PER_CORE];
    logic [WARPS_PER_CORE-1:0] fetch_done;
    instruction_t              fetched [WARPS_PER_CORE];
    logic [WARP_W-1:0]         current_warp;

    logic                        store_req;
    logic [THREADS_PER_WARP-1:0] lane_busy;

    // Decoded fields of the current warp
    alu_op_t   alu_op;
    logic      use_imm;
    data_t     imm;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      reg_write;
    logic      mem_write;
    logic      halt;

    data_t rs1_data [THREADS_PER_WARP];
    data_t rs2_data [THREADS_PER_WARP];
    data_t alu_result [THREADS_PER_WARP];

    logic decode_en;
    logic execute_en;
    logic write_en;

    assign decode_en  = (warp_state[current_warp] == WARP_DECODE);
    assign execute_en = (warp_state[current_warp] == WARP_EXECUTE);
    assign write_en   = reg_write && (warp_state[current_warp] == WARP_UPDATE);

    warp_scheduler #(
        .WARPS_PER_CORE  (WARPS_PER_CORE),
        .THREADS_PER_WARP(THREADS_PER_WARP)
    ) scheduler (
        .clk, .reset, .start, .num_warps, .base_addr, .fetch_done, .halt, .lane_busy,
        .warp_state, .pc, .current_warp, .store_req, .done
    );

    for (genvar w = 0; w < WARPS_PER_CORE; w++) begin : g_warp
        instr_fetcher fetcher (
            .clk, .reset,
            .warp_state (warp_state[w]),
            .pc         (pc[w]),
            .imem_ready (imem_ready[w]),
            .imem_data  (imem_data[w]),
            .imem_valid (imem_valid[w]),
            .imem_addr  (imem_addr[w]),
            .fetch_done (fetch_done[w]),
            .instruction(fetched[w])
        );
    end

    instr_decoder decoder (
        .clk, .reset, .decode_en,
        .instruction(fetched[current_warp]),
        .alu_op, .use_imm, .imm, .rd, .rs1, .rs2, .reg_write, .mem_write, .halt
    );

    vector_reg_file #(
        .WARPS_PER_CORE  (WARPS_PER_CORE),
        .THREADS_PER_WARP(THREADS_PER_WARP)
    ) reg_file (
        .clk, .reset, .current_warp, .rs1, .rs2, .rd, .write_en,
        .wdata(alu_result), .rs1_data, .rs2_data
    );

    for (genvar l = 0; l < THREADS_PER_WARP; l++) begin : g_lane
        lane_alu alu (
            .clk, .reset, .execute_en, .alu_op, .use_imm, .imm,
            .rs1_data(rs1_data[l]),
            .rs2_data(rs2_data[l]),
            .result  (alu_result[l])
        );

        lane_store_unit store_unit (
            .clk, .reset, .store_req, .mem_write, .imm,
            .rs1_data   (rs1_data[l]),
            .rs2_data   (rs2_data[l]),
            .dmem_wready(dmem_wready[l]),
            .dmem_wvalid(dmem_wvalid[l]),
            .dmem_waddr (dmem_waddr[l]),
            .dmem_wdata (dmem_wdata[l]),
            .busy       (lane_busy[l])
        );
    end

endmodule

`default_nettype wire

/* include/tb_isa.svh */
`ifndef TB_ISA_SVH
`define TB_ISA_SVH

// Program building helpers for use inside the testbench module

localparam simt_pkg::alu_op_t ISA_OPS [6] = '{
    simt_pkg::ALU_ADD, simt_pkg::ALU_SUB, simt_pkg::ALU_AND,
    simt_pkg::ALU_OR,  simt_pkg::ALU_XOR, simt_pkg::ALU_SLT
};

function automatic simt_pkg::instruction_t isa_reg(input simt_pkg::alu_op_t op,
                                                   input simt_pkg::reg_addr_t rd,
                                                   input simt_pkg::reg_addr_t rs1,
                                                   input simt_pkg::reg_addr_t rs2);
    return {7'b0, rs2, rs1, op, rd, simt_pkg::OP_REG};
endfunction

function automatic simt_pkg::instruction_t isa_imm(input simt_pkg::alu_op_t op,
                                                   input simt_pkg::reg_addr_t rd,
                                                   input simt_pkg::reg_addr_t rs1,
                                                   input logic [11:0] imm);
    return {imm, rs1, op, rd, simt_pkg::OP_IMM};
endfunction

// Stores rs2 to rs1 + imm
function automatic simt_pkg::instruction_t isa_store(input simt_pkg::reg_addr_t rs1,
                                                     input simt_pkg::reg_addr_t rs2,
                                                     input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], simt_pkg::OP_STORE};
endfunction

function automatic simt_pkg::instruction_t isa_halt();
    return {25'b0, simt_pkg::OP_HALT};
endfunction

`endif

/* tb/tb_compute_core.sv */
`default_nettype none

module tb_compute_core;
    timeunit 1ns;
    timeprecision 1ns;
    import simt_pkg::*;

    `include "tb_isa.svh"

    localparam int         WARPS      = 2;
    localparam int         THREADS    = 4;
    localparam logic [15:0] SEED      = 16'd5;
    localparam int         ALU_COUNT  = 12;
    localparam int         PROG_LEN   = ALU_COUNT + THREADS + 1;
    localparam imem_addr_t BASE       = 8'h20;
    localparam int         RUN_CYCLES = PROG_LEN * WARPS * 40 + 200;

    logic                clk = 1'b0;
    logic                reset;
    logic                start;
    logic [1:0]          num_warps;
    imem_addr_t          base_addr;
    logic                done;
    logic [WARPS-1:0]    imem_valid;
    imem_addr_t          imem_addr [WARPS];
    logic [WARPS-1:0]    imem_ready;
    instruction_t        imem_data [WARPS];
    logic [THREADS-1:0]  dmem_wvalid;
    dmem_addr_t          dmem_waddr [THREADS];
    data_t               dmem_wdata [THREADS];
    logic [THREADS-1:0]  dmem_wready;

    logic [15:0]      lfsr = SEED;
    int               errors = 0;
    data_t            imem [WARPS][256];
    data_t            dmem [256];
    data_t            exp_mem [256];
    bit               written [256];
    int               write_count;
    int               exp_writes;
    int               fetch_count [WARPS];
    logic [WARPS-1:0] halt_fetched;
    int               launched;
    bit               done_seen;
    bit               idle_reported;

    compute_core #(
        .WARPS_PER_CORE  (WARPS),
        .THREADS_PER_WARP(THREADS)
    ) u_dut (
        .clk, .reset, .start, .num_warps, .base_addr, .done,
        .imem_valid, .imem_addr, .imem_ready, .imem_data,
        .dmem_wvalid, .dmem_waddr, .dmem_wdata, .dmem_wready
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            value = {value[30:0], lfsr[15]};
            lfsr  = {lfsr[14:0], fb};
        end
        return value;
    endfunction

    function automatic data_t dmem_fill(input int addr);
        return {8'hd0, 8'(addr), 8'(~addr), 8'(addr)};
    endfunction

    function automatic data_t alu_model(input logic [2:0] op, input data_t a, input data_t b);
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // 12 ALU ops, one store per lane slot, then halt
    task automatic gen_programs();
        alu_op_t   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t dest [ALU_COUNT];
        for (int w = 0; w < WARPS; w++) begin
            for (int a = 0; a < 256; a++) begin
                imem[w][a] = {8'(w), 8'(~a), 8'h5a, 8'(a)};
            end
            for (int i = 0; i < ALU_COUNT; i++) begin
                op  = ISA_OPS[int'(rand_bits(8)) % 6];
                rd  = reg_addr_t'(1 + int'(rand_bits(8)) % 30);
                rs1 = reg_addr_t'(rand_bits(5));
                rs2 = reg_addr_t'(rand_bits(5));
                // Chain on the previous result half the time
                if (i > 0 && rand_bits(1) == 1) rs1 = dest[i-1];
                if (i == 0) rs1 = TID_REG;
                if (i == 1) rs2 = '0;
                dest[i] = rd;
                if (rand_bits(1) == 1) begin
                    imem[w][BASE + i] = isa_imm(op, rd, rs1, 12'(rand_bits(12)));
                end else begin
                    imem[w][BASE + i] = isa_reg(op, rd, rs1, rs2);
                end
            end
            for (int k = 0; k < THREADS; k++) begin
                rs2 = dest[ALU_COUNT - 1 - int'(rand_bits(3)) % ALU_COUNT];
                imem[w][BASE + ALU_COUNT + k] = isa_store(TID_REG, rs2, 12'(32 * k));
            end
            imem[w][BASE + PROG_LEN - 1] = isa_halt();
        end
    endtask

    // Interprets the programs per warp and lane from the encoding rules
    task automatic build_expected(input int n_warps);
        data_t      regs [32];
        data_t      word;
        data_t      op_a;
        data_t      op_b;
        logic [6:0] opc;
        dmem_addr_t addr;
        for (int a = 0; a < 256; a++) exp_mem[a] = dmem_fill(a);
        exp_writes = 0;
        for (int w = 0; w < n_warps; w++) begin
            for (int l = 0; l < THREADS; l++) begin
                for (int r = 0; r < 32; r++) regs[r] = '0;
                regs[31] = data_t'(w * THREADS + l);
                for (int i = 0; i < PROG_LEN; i++) begin
                    word = imem[w][BASE + i];
                    opc  = word[6:0];
                    op_a = regs[word[19:15]];
                    if (opc == OP_REG || opc == OP_IMM) begin
                        op_b = (opc == OP_REG) ? regs[word[24:20]]
                                               : {{20{word[31]}}, word[31:20]};
                        if (word[11:7] != 5'd0 && word[11:7] != 5'd31) begin
                            regs[word[11:7]] = alu_model(word[14:12], op_a, op_b);
                        end
                    end else if (opc == OP_STORE) begin
                        addr = 8'(op_a + {{20{word[31]}}, word[31:25], word[11:7]});
                        exp_mem[addr] = regs[word[24:20]];
                        exp_writes++;
                    end
                end
            end
        end
    endtask

    always_comb begin
        for (int w = 0; w < WARPS; w++) begin
            imem_data[w] = imem[w][imem_addr[w]];
        end
    end

    always @(posedge clk) begin
        #2;
        imem_ready  = WARPS'(rand_bits(WARPS));
        dmem_wready = THREADS'(rand_bits(THREADS));
    end

    // Handshakes are sampled mid-cycle, where they match the next edge
    always @(negedge clk) begin
        if (!reset) begin
            for (int w = 0; w < WARPS; w++) begin
                if (imem_valid[w] && imem_ready[w]) begin
                    check_value($sformatf("imem_addr[%0d]", w), imem_addr[w],
                                32'(BASE) + fetch_count[w]);
                    if (imem_data[w][6:0] == OP_HALT) halt_fetched[w] = 1'b1;
                    fetch_count[w]++;
                end
                if (w >= launched && imem_valid[w] && !idle_reported) begin
                    errors++;
                    idle_reported = 1'b1;
                    $display("Warp %0d requested an instruction but was never launched", w);
                end
            end
            for (int l = 0; l < THREADS; l++) begin
                if (dmem_wvalid[l] && dmem_wready[l]) begin
                    if (written[dmem_waddr[l]]) begin
                        errors++;
                        $display("Lane %0d wrote address %h a second time", l, dmem_waddr[l]);
                    end
                    written[dmem_waddr[l]] = 1'b1;
                    dmem[dmem_waddr[l]]    = dmem_wdata[l];
                    write_count++;
                end
            end
            if (done && !done_seen) begin
                done_seen = 1'b1;
                for (int w = 0; w < launched; w++) begin
                    if (!halt_fetched[w]) begin
                        errors++;
                        $display("Done rose before warp %0d fetched its halt", w);
                    end
                end
            end
        end
    end

    task automatic run_core(input int n_warps);
        @(posedge clk);
        #2;
        reset     = 1'b1;
        start     = 1'b0;
        num_warps = 2'(n_warps);

        // Bookkeeping restarts only once the core is held in reset
        launched      = n_warps;
        done_seen     = 1'b0;
        idle_reported = 1'b0;
        halt_fetched  = '0;
        write_count   = 0;
        for (int w = 0; w < WARPS; w++) fetch_count[w] = 0;
        for (int a = 0; a < 256; a++) begin
            dmem[a]    = dmem_fill(a);
            written[a] = 1'b0;
        end
        build_expected(n_warps);

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("done", done, 0);
        check_value("imem_valid", imem_valid, 0);
        check_value("dmem_wvalid", dmem_wvalid, 0);

        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        while (!done) begin
            @(posedge clk);
            #2;
        end
        repeat (2) @(posedge clk);

        for (int a = 0; a < 256; a++) begin
            check_value($sformatf("dmem[%02h]", a), dmem[a], exp_mem[a]);
        end
        check_value("write_count", write_count, exp_writes);
        for (int w = 0; w < n_warps; w++) begin
            check_value($sformatf("fetch_count[%0d]", w), fetch_count[w], PROG_LEN);
        end
    endtask

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        num_warps   = '0;
        base_addr   = BASE;
        imem_ready  = '0;
        dmem_wready = '0;
        gen_programs();
        run_core(WARPS);
        run_core(1);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Covers both runs
    initial begin
        repeat (RUN_CYCLES) @(posedge clk);
        $display("Timeout: the core did not finish within %0d cycles", RUN_CYCLES);
        $display("Errors: %0d", errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
hw/simt_pkg.sv
hw/instr_fetcher.sv
hw/instr_decoder.sv
hw/vector_reg_file.sv
hw/lane_alu.sv
hw/lane_store_unit.sv
hw/warp_scheduler.sv
hw/compute_core.sv
tb/tb_compute_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, everything goes to sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_compute_core \
    > sim.log 2>&1 && ./obj_dir/Vtb_compute_core >> sim.log 2>&1 \
    || echo "=== FAIL ===" >> sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
